// ==== source/core_cfg_pkg.sv ====
`default_nettype none

package core_cfg_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Register file sizing
    ////////////////////////////////////////////////////////////////////////////

    localparam int NUM_ARCH_REGS = 32;  // RISC-V integer registers
    localparam int NUM_PHYS_REGS = 64;  // Rename pool, arch set plus 32 spares
    localparam int MAX_ROB_DEPTH = 32;  // Upper bound for any ROB instance

    localparam int ARCH_REG_W = $clog2(NUM_ARCH_REGS);
    localparam int PHYS_REG_W = $clog2(NUM_PHYS_REGS);
    localparam int ROB_IDX_W  = $clog2(MAX_ROB_DEPTH);

    ////////////////////////////////////////////////////////////////////////////
    // Index and vector types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [ARCH_REG_W-1:0]    arch_reg_t;   // Architectural register
    typedef logic [PHYS_REG_W-1:0]    phys_reg_t;   // Physical register tag
    typedef logic [ROB_IDX_W-1:0]     rob_idx_t;    // ROB slot
    typedef logic [NUM_PHYS_REGS-1:0] phys_vec_t;   // One bit per phys reg

    // Phys regs holding the committed arch state after reset
    localparam phys_vec_t ARCH_BOUND_VEC = phys_vec_t'({NUM_ARCH_REGS{1'b1}});

endpackage

`default_nettype wire

// ==== source/rename_types_pkg.sv ====
`default_nettype none

package rename_types_pkg;

    import core_cfg_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Dispatch side
    ////////////////////////////////////////////////////////////////////////////

    // Decoded register fields of one instruction
    typedef struct packed {
        logic      has_dest;    // Writes a destination register
        arch_reg_t dest;
        arch_reg_t src1;
        arch_reg_t src2;
    } dispatch_req_t;

    // Renamed operands, valid in the accept cycle
    typedef struct packed {
        phys_reg_t dest_phys;   // Newly allocated tag
        phys_reg_t src1_phys;
        logic      src1_ready;  // Value already produced
        phys_reg_t src2_phys;
        logic      src2_ready;
        rob_idx_t  rob_idx;     // Slot taken in the ROB
    } dispatch_rsp_t;

    ////////////////////////////////////////////////////////////////////////////
    // Reorder buffer side
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic      has_dest;
        arch_reg_t dest;        // Architectural destination
        phys_reg_t new_phys;    // Tag written by this instruction
        phys_reg_t old_phys;    // Previous mapping, freed at commit
    } rob_entry_t;

    // Retired instruction as seen outside the core
    typedef struct packed {
        rob_idx_t   rob_idx;
        rob_entry_t entry;
    } commit_t;

endpackage

`default_nettype wire

// ==== source/map_table.sv ====
`timescale 1ns/1ns
`default_nettype none

module map_table import core_cfg_pkg::*; (
    input  logic      clock,
    input  logic      rst_n,

    // Lookup ports
    input  arch_reg_t src1,
    input  arch_reg_t src2,
    input  arch_reg_t dest,
    output phys_reg_t src1_map,
    output phys_reg_t src2_map,
    output phys_reg_t dest_map,     // Current mapping, becomes old_phys

    // Rename update for dest
    input  logic      write_en,
    input  phys_reg_t write_phys
);

    phys_reg_t map [NUM_ARCH_REGS];  // Speculative arch to phys mapping

    ////////////////////////////////////////////////////////////////////////////
    // Reads
    ////////////////////////////////////////////////////////////////////////////

    // Combinational, so sources see the mapping before this write lands
    assign src1_map = map[src1];
    assign src2_map = map[src2];
    assign dest_map = map[dest];

    ////////////////////////////////////////////////////////////////////////////
    // Update
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                map[i] <= phys_reg_t'(i);           // Identity mapping
            end
        end else if (write_en) begin
            map[dest] <= write_phys;                // Newest producer of dest
        end
    end

endmodule

`default_nettype wire

// ==== source/phys_reg_status.sv ====
`timescale 1ns/1ns
`default_nettype none

module phys_reg_status import core_cfg_pkg::*; (
    input  logic      clock,
    input  logic      rst_n,

    // Allocation toward dispatch
    input  logic      alloc_en,
    output phys_reg_t alloc_phys,       // Lowest free tag
    output logic      free_avail,       // At least one tag is free

    // Release from commit
    input  logic      release_en,
    input  phys_reg_t release_phys,

    // Completion from the execution side
    input  logic      complete_valid,
    input  phys_reg_t complete_tag,
    output phys_vec_t complete_vec
);

    phys_vec_t free_vec;        // 1 = tag available for allocation
    phys_vec_t done_vec;        // 1 = tag holds a produced value

    assign complete_vec = done_vec;     // Registered view, no bypass

    ////////////////////////////////////////////////////////////////////////////
    // Priority search for the lowest free tag
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        alloc_phys = '0;
        free_avail = 1'b0;
        // Scan downward so the last hit is the lowest index
        for (int i = NUM_PHYS_REGS - 1; i >= 0; i--) begin
            if (free_vec[i]) begin
                alloc_phys = phys_reg_t'(i);
                free_avail = 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Free list
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            free_vec <= ~ARCH_BOUND_VEC;            // Upper half free
        end else begin
            // Released tag is never the one being allocated
            if (release_en) free_vec[release_phys] <= 1'b1;
            if (alloc_en && free_avail) free_vec[alloc_phys] <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Complete list
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            done_vec <= ARCH_BOUND_VEC;             // Arch state is complete
        end else begin
            if (complete_valid) done_vec[complete_tag] <= 1'b1;
            // New producer starts out pending
            if (alloc_en && free_avail) done_vec[alloc_phys] <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== source/rob.sv ====
`timescale 1ns/1ns
`default_nettype none

module rob import core_cfg_pkg::*, rename_types_pkg::*; #(
    parameter int ROB_DEPTH = 16        // Power of two, 4 to 32
) (
    input  logic       clock,
    input  logic       rst_n,

    // Allocation at dispatch
    input  logic       push,
    input  rob_entry_t push_entry,
    output logic       rob_full,
    output rob_idx_t   rob_tail,        // Slot the next push lands in

    // Completion status of all tags
    input  phys_vec_t  complete_vec,

    // In-order retirement
    output logic       commit_valid,
    output commit_t    commit,
    input  logic       commit_ready,

    // Freed mapping back to the free list
    output logic       release_en,
    output phys_reg_t  release_phys
);

    localparam int       SLOT_W   = $clog2(ROB_DEPTH);
    localparam int       CNT_W    = $clog2(MAX_ROB_DEPTH) + 1;
    localparam rob_idx_t IDX_MASK = rob_idx_t'(ROB_DEPTH - 1);

    rob_entry_t              slots [ROB_DEPTH];     // Payload, no reset
    rob_idx_t                head;
    rob_idx_t                tail;
    logic      [CNT_W-1:0]   count;                 // Occupied slots
    rob_entry_t              head_entry;
    logic                    head_done;
    logic                    pop;

    // Wrap within the configured depth
    function automatic rob_idx_t next_idx(input rob_idx_t idx);
        next_idx = rob_idx_t'(idx + 1'b1) & IDX_MASK;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Head status
    ////////////////////////////////////////////////////////////////////////////

    assign head_entry = slots[head[SLOT_W-1:0]];

    // No destination means nothing to wait for
    assign head_done = !head_entry.has_dest || complete_vec[head_entry.new_phys];

    assign commit_valid = (count != '0) && head_done;
    assign pop          = commit_valid && commit_ready;

    assign commit.rob_idx = head;
    assign commit.entry   = head_entry;

    assign release_en   = pop && head_entry.has_dest;
    assign release_phys = head_entry.old_phys;     // Previous owner of dest

    assign rob_full = (count == CNT_W'(ROB_DEPTH));
    assign rob_tail = tail;

    ////////////////////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (push) begin
            slots[tail[SLOT_W-1:0]] <= push_entry;  // Visible as head next cycle
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;                            // Empty
        end else begin
            if (push) tail <= next_idx(tail);
            if (pop)  head <= next_idx(head);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;            // Idle or both
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/dispatch_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module dispatch_ctrl import core_cfg_pkg::*, rename_types_pkg::*; #(
    parameter int ROB_DEPTH = 16
) (
    // Dispatch handshake
    input  logic          dispatch_valid,
    input  dispatch_req_t dispatch_req,
    output logic          dispatch_ready,
    output dispatch_rsp_t dispatch_rsp,

    // ROB status
    input  logic          rob_full,
    input  rob_idx_t      rob_tail,

    // Free list and completion state
    input  logic          free_avail,
    input  phys_reg_t     alloc_phys,
    input  phys_vec_t     complete_vec,

    // Map table lookups
    input  phys_reg_t     src1_map,
    input  phys_reg_t     src2_map,
    input  phys_reg_t     dest_map,

    // Actions for this cycle
    output logic          accept,
    output logic          alloc_en,       // Take alloc_phys, update map
    output rob_entry_t    rob_entry
);

    localparam rob_idx_t IDX_MASK = rob_idx_t'(ROB_DEPTH - 1);

    phys_reg_t new_phys;

    ////////////////////////////////////////////////////////////////////////////
    // Accept decision
    ////////////////////////////////////////////////////////////////////////////

    // Needs a ROB slot, and a free tag only if it writes a register
    assign dispatch_ready = !rob_full && (!dispatch_req.has_dest || free_avail);
    assign accept         = dispatch_valid && dispatch_ready;
    assign alloc_en       = accept && dispatch_req.has_dest;

    assign new_phys = dispatch_req.has_dest ? alloc_phys : '0;

    ////////////////////////////////////////////////////////////////////////////
    // ROB entry and response
    ////////////////////////////////////////////////////////////////////////////

    assign rob_entry.has_dest = dispatch_req.has_dest;
    assign rob_entry.dest     = dispatch_req.dest;
    assign rob_entry.new_phys = new_phys;
    assign rob_entry.old_phys = dest_map;           // Freed when this retires

    assign dispatch_rsp.dest_phys  = new_phys;
    assign dispatch_rsp.src1_phys  = src1_map;
    assign dispatch_rsp.src1_ready = complete_vec[src1_map];
    assign dispatch_rsp.src2_phys  = src2_map;
    assign dispatch_rsp.src2_ready = complete_vec[src2_map];
    assign dispatch_rsp.rob_idx    = rob_tail & IDX_MASK;   // Slot within depth

endmodule

`default_nettype wire

// ==== source/rename_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module rename_core import core_cfg_pkg::*, rename_types_pkg::*; #(
    parameter int ROB_DEPTH = 16        // Power of two, 4 to 32
) (
    input  logic          clock,
    input  logic          rst_n,

    // Dispatch, one instruction per cycle
    input  logic          dispatch_valid,
    input  dispatch_req_t dispatch_req,
    output logic          dispatch_ready,
    output dispatch_rsp_t dispatch_rsp,

    // Completion tags from execution
    input  logic          complete_valid,
    input  phys_reg_t     complete_tag,

    // In-order commit
    output logic          commit_valid,
    output commit_t       commit,
    input  logic          commit_ready
);

    ////////////////////////////////////////////////////////////////////////////
    // Internal wires
    ////////////////////////////////////////////////////////////////////////////

    logic       accept;         // Dispatch transfer this cycle
    logic       alloc_en;
    rob_entry_t rob_entry;
    logic       rob_full;
    rob_idx_t   rob_tail;
    logic       free_avail;
    phys_reg_t  alloc_phys;
    phys_vec_t  complete_vec;
    phys_reg_t  src1_map, src2_map, dest_map;
    logic       release_en;     // Commit frees old_phys
    phys_reg_t  release_phys;

    dispatch_ctrl #(.ROB_DEPTH(ROB_DEPTH)) i_dispatch_ctrl (
        .dispatch_valid (dispatch_valid),
        .dispatch_req   (dispatch_req),
        .dispatch_ready (dispatch_ready),
        .dispatch_rsp   (dispatch_rsp),
        .rob_full       (rob_full),
        .rob_tail       (rob_tail),
        .free_avail     (free_avail),
        .alloc_phys     (alloc_phys),
        .complete_vec   (complete_vec),
        .src1_map       (src1_map),
        .src2_map       (src2_map),
        .dest_map       (dest_map),
        .accept         (accept),
        .alloc_en       (alloc_en),
        .rob_entry      (rob_entry)
    );

    map_table i_map_table (
        .clock      (clock),
        .rst_n      (rst_n),
        .src1       (dispatch_req.src1),
        .src2       (dispatch_req.src2),
        .dest       (dispatch_req.dest),
        .src1_map   (src1_map),
        .src2_map   (src2_map),
        .dest_map   (dest_map),
        .write_en   (alloc_en),         // Rename dest on allocation
        .write_phys (alloc_phys)
    );

    phys_reg_status i_phys_reg_status (
        .clock          (clock),
        .rst_n          (rst_n),
        .alloc_en       (alloc_en),
        .alloc_phys     (alloc_phys),
        .free_avail     (free_avail),
        .release_en     (release_en),
        .release_phys   (release_phys),
        .complete_valid (complete_valid),
        .complete_tag   (complete_tag),
        .complete_vec   (complete_vec)
    );

    rob #(.ROB_DEPTH(ROB_DEPTH)) i_rob (
        .clock        (clock),
        .rst_n        (rst_n),
        .push         (accept),
        .push_entry   (rob_entry),
        .rob_full     (rob_full),
        .rob_tail     (rob_tail),
        .complete_vec (complete_vec),
        .commit_valid (commit_valid),
        .commit       (commit),
        .commit_ready (commit_ready),
        .release_en   (release_en),
        .release_phys (release_phys)
    );

endmodule

`default_nettype wire

// ==== bench/rename_core_chk.sv ====
`timescale 1ns/1ns
`default_nettype none

module rename_core_chk import rename_types_pkg::*; (
    input logic    clock,
    input logic    rst_n,
    input logic    accept,          // Dispatch transfer
    input logic    dispatch_ready,
    input logic    commit_valid,
    input commit_t commit,
    input logic    commit_ready
);

    logic [5:0] occ;                // In flight, counted from the handshakes

    always_ff @(posedge clock) begin
        if (!rst_n) occ <= '0;
        else occ <= occ + 6'(accept) - 6'(commit_valid && commit_ready);
    end

    // Stalled commit keeps its payload
    commit_hold: assert property (@(posedge clock) disable iff (!rst_n)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit))
        else $error("commit dropped or changed while commit_ready was low");

    reset_state: assert property (@(posedge clock)
        !rst_n |=> dispatch_ready && !commit_valid)   // Empty ROB, free tags
        else $error("handshake outputs wrong after reset");

    commit_not_empty: assert property (@(posedge clock) disable iff (!rst_n)
        commit_valid |-> occ != '0)
        else $error("commit offered with an empty ROB");

endmodule

bind rename_core rename_core_chk i_chk (
    .clock          (clock),
    .rst_n          (rst_n),
    .accept         (accept),
    .dispatch_ready (dispatch_ready),
    .commit_valid   (commit_valid),
    .commit         (commit),
    .commit_ready   (commit_ready)
);

`default_nettype wire

// ==== bench/rename_core_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module rename_core_tb import core_cfg_pkg::*, rename_types_pkg::*; ();

    localparam int ROB_DEPTH = 8;
    localparam int N_RAND    = 300;         // Random rows after the directed part

    typedef enum logic [2:0] {OP_IDLE, OP_DISP, OP_CMPL, OP_CMPL_PEND, OP_RDY} op_e;

    // One row is one clock cycle
    typedef struct packed {
        op_e           op;
        dispatch_req_t req;
        phys_reg_t     arg;                 // Tag, in-flight pick, or commit_ready in bit 0
        logic          chk;                 // Hand-computed dest_phys present
        phys_reg_t     exp;
    } row_t;

    logic          clock;
    logic          rst_n;
    logic          dispatch_valid;
    dispatch_req_t dispatch_req;
    logic          dispatch_ready;
    dispatch_rsp_t dispatch_rsp;
    logic          complete_valid;
    phys_reg_t     complete_tag;
    logic          commit_valid;
    commit_t       commit;
    logic          commit_ready;

    row_t      rows[$];
    phys_reg_t map_m [NUM_ARCH_REGS];       // Reference map table
    phys_vec_t free_m;
    phys_vec_t done_m;
    commit_t   rob_m[$];                    // In-flight instructions, oldest first
    rob_idx_t  tail_m;

    rename_core #(.ROB_DEPTH(ROB_DEPTH)) i_dut (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic add_row(input op_e op, input logic hd, input int dest, input int s1,
                           input int s2, input int arg, input int exp);
        row_t r;
        r.op  = op;
        r.req = '{has_dest: hd, dest: arch_reg_t'(dest), src1: arch_reg_t'(s1),
                  src2: arch_reg_t'(s2)};
        r.arg = phys_reg_t'(arg);
        r.chk = (exp >= 0);                 // Negative means model only
        r.exp = phys_reg_t'(exp);
        rows.push_back(r);
    endtask

    function automatic phys_reg_t lowest_free();
        for (int i = 0; i < NUM_PHYS_REGS; i++) begin
            if (free_m[i]) return phys_reg_t'(i);
        end
        return '0;
    endfunction

    task automatic expect_eq(input string name, input logic [31:0] act, input logic [31:0] exp);
        assert (act === exp) else begin
            $display("Fail at %0t ns: %s expected %0h, actual %0h", $time, name, exp, act);
            $display("SOME TESTS FAILED");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Apply one row, check outputs, step the model
    ////////////////////////////////////////////////////////////////////////////

    task automatic run_row(input row_t r);
        dispatch_rsp_t exp_rsp;
        commit_t       exp_commit;
        logic          exp_ready;
        logic          exp_cv;
        logic          push;
        logic          pop;
        phys_reg_t     tag;
        tag = r.arg;
        if (r.op == OP_CMPL_PEND && rob_m.size() != 0)
            tag = rob_m[r.arg % rob_m.size()].entry.new_phys;  // Some in-flight producer
        dispatch_valid = (r.op == OP_DISP);
        dispatch_req   = r.req;
        complete_valid = (r.op == OP_CMPL || r.op == OP_CMPL_PEND);
        complete_tag   = tag;
        if (r.op == OP_RDY) commit_ready = r.arg[0];
        #2;                                 // Settled, well before the next edge
        exp_ready = (rob_m.size() < ROB_DEPTH) && (!r.req.has_dest || free_m != '0);
        exp_cv = (rob_m.size() != 0) &&
                 (!rob_m[0].entry.has_dest || done_m[rob_m[0].entry.new_phys]);
        push = dispatch_valid && exp_ready;
        pop  = exp_cv && commit_ready;
        expect_eq("dispatch_ready", dispatch_ready, exp_ready);
        expect_eq("commit_valid", commit_valid, exp_cv);
        if (exp_cv) expect_eq("commit", commit, rob_m[0]);
        exp_rsp = '{dest_phys: r.req.has_dest ? lowest_free() : '0,
                    src1_phys: map_m[r.req.src1], src1_ready: done_m[map_m[r.req.src1]],
                    src2_phys: map_m[r.req.src2], src2_ready: done_m[map_m[r.req.src2]],
                    rob_idx: tail_m};
        if (push) begin
            expect_eq("dispatch_rsp", dispatch_rsp, exp_rsp);
            if (r.chk) expect_eq("dest_phys", dispatch_rsp.dest_phys, r.exp);
        end
        // Same update the DUT makes at the coming edge
        if (complete_valid) done_m[tag] = 1'b1;
        if (push) begin
            exp_commit = '{rob_idx: tail_m, entry: '{has_dest: r.req.has_dest,
                           dest: r.req.dest, new_phys: exp_rsp.dest_phys,
                           old_phys: map_m[r.req.dest]}};
            if (r.req.has_dest) begin
                free_m[exp_rsp.dest_phys] = 1'b0;
                done_m[exp_rsp.dest_phys] = 1'b0;   // Fresh producer is pending
                map_m[r.req.dest]         = exp_rsp.dest_phys;
            end
            tail_m = rob_idx_t'((tail_m + 1) % ROB_DEPTH);
        end
        if (pop) begin
            if (rob_m[0].entry.has_dest) free_m[rob_m[0].entry.old_phys] = 1'b1;
            void'(rob_m.pop_front());
        end
        if (push) rob_m.push_back(exp_commit);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Table and main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int full_exp[9];
        int sel;
        full_exp = '{4, 5, 6, 32, 36, 37, 38, 39, -1};     // Last one is refused
        void'($urandom(32'h2449));
        rst_n          = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_req   = '0;
        complete_valid = 1'b0;
        complete_tag   = '0;
        commit_ready   = 1'b0;
        for (int i = 0; i < NUM_ARCH_REGS; i++) map_m[i] = phys_reg_t'(i);
        free_m = 64'hFFFF_FFFF_0000_0000;   // Spares free
        done_m = 64'h0000_0000_FFFF_FFFF;   // Arch state complete
        tail_m = '0;
        add_row(OP_IDLE, 0, 0, 0, 0, 0, -1);
        add_row(OP_DISP, 1, 1, 2, 3, 0, 32);  // First allocation
        add_row(OP_DISP, 1, 4, 1, 0, 0, 33);  // Reads p32, not ready
        add_row(OP_DISP, 1, 1, 1, 4, 0, 34);
        add_row(OP_CMPL, 0, 0, 0, 0, 34, -1); // Youngest completes first
        add_row(OP_RDY,  0, 0, 0, 0, 1, -1);
        add_row(OP_CMPL, 0, 0, 0, 0, 33, -1);
        add_row(OP_CMPL, 0, 0, 0, 0, 32, -1);
        add_row(OP_DISP, 1, 5, 1, 4, 0, 35);  // Sources now ready
        add_row(OP_DISP, 1, 6, 0, 0, 0, 1);   // Released p1 is lowest
        add_row(OP_RDY,  0, 0, 0, 0, 0, -1);  // Hold a valid commit
        add_row(OP_IDLE, 0, 0, 0, 0, 0, -1);
        add_row(OP_RDY,  0, 0, 0, 0, 1, -1);
        add_row(OP_DISP, 0, 7, 7, 7, 0, 0);   // No destination
        add_row(OP_CMPL, 0, 0, 0, 0, 35, -1);
        add_row(OP_CMPL, 0, 0, 0, 0, 1, -1);
        add_row(OP_IDLE, 0, 0, 0, 0, 0, -1);
        add_row(OP_IDLE, 0, 0, 0, 0, 0, -1);
        add_row(OP_RDY,  0, 0, 0, 0, 0, -1);
        for (int i = 0; i < 9; i++) add_row(OP_DISP, 1, 8 + i, 0, 0, 0, full_exp[i]);
        add_row(OP_RDY,  0, 0, 0, 0, 1, -1);
        add_row(OP_CMPL, 0, 0, 0, 0, 4, -1);
        add_row(OP_IDLE, 0, 0, 0, 0, 0, -1);  // Head retires, frees p8
        add_row(OP_DISP, 1, 20, 8, 0, 0, 8);
        for (int i = 0; i < N_RAND; i++) begin
            sel = $urandom_range(9, 0);
            if (sel < 4)
                add_row(OP_DISP, $urandom_range(7, 0) != 0, $urandom_range(31, 0),
                        $urandom_range(31, 0), $urandom_range(31, 0), 0, -1);
            else if (sel < 6) add_row(OP_CMPL_PEND, 0, 0, 0, 0, $urandom_range(63, 0), -1);
            else if (sel == 6) add_row(OP_CMPL, 0, 0, 0, 0, $urandom_range(63, 0), -1);
            else if (sel == 7) add_row(OP_RDY, 0, 0, 0, 0, $urandom_range(3, 0) != 0, -1);
            else add_row(OP_IDLE, 0, 0, 0, 0, 0, -1);
        end
        repeat (16) @(posedge clock);
        #1;
        rst_n = 1'b1;
        foreach (rows[i]) begin
            run_row(rows[i]);
            @(posedge clock);
            #1;
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

    // Bound on run time, from the table length
    initial begin
        #1;
        repeat (rows.size() * 20 + 16) @(posedge clock);
        $display("Watchdog expired before all %0d table rows were applied", rows.size());
        $display("SOME TESTS FAILED");
        $fatal(1, "Run did not finish in time");
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
source/core_cfg_pkg.sv
source/rename_types_pkg.sv
source/map_table.sv
source/phys_reg_status.sv
source/rob.sv
source/dispatch_ctrl.sv
source/rename_core.sv
bench/rename_core_chk.sv
bench/rename_core_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= rename_core_tb
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG) || { echo "Simulation did not complete"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
